// ==== hw/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  rv_pkg::instr_word_t     instr,
    input  logic                    valid,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output logic [2:0]              funct3,
    output logic [rv_pkg::xlen-1:0] imm,
    output rv_pkg::alu_op_t         alu_op,
    output rv_pkg::upper_sel_t      upper_sel,
    output logic                    alu_src,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    branch,
    output logic                    reg_write,
    output rv_pkg::wb_sel_t         wb_sel
);
    import rv_pkg::*;

    logic supported;

    always_comb begin
        rs1       = instr.r_fmt.rs1;
        rs2       = instr.r_fmt.rs2;
        rd        = instr.r_fmt.rd;
        funct3    = instr.r_fmt.funct3;
        imm       = '0;
        alu_op    = alu_add;
        upper_sel = upper_reg;
        alu_src   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        reg_write = 1'b0;
        wb_sel    = wb_alu;
        supported = 1'b0;

        case (instr.r_fmt.opcode)
            op_lui, op_auipc: begin
                imm       = {instr.u_fmt.imm_31_12, 12'b0};
                upper_sel = (instr.u_fmt.opcode == op_lui) ? upper_zero : upper_pc;
                alu_src   = 1'b1;
                reg_write = 1'b1;
                supported = 1'b1;
            end
            op_op_imm: begin // addi only
                imm       = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
                alu_src   = 1'b1;
                reg_write = 1'b1;
                supported = (funct3 == 3'b000);
            end
            op_op: begin
                reg_write = 1'b1;
                supported = (instr.r_fmt.funct7 == 7'h00);
                case (funct3)
                    3'b000: begin
                        alu_op    = (instr.r_fmt.funct7 == 7'h20) ? alu_sub : alu_add;
                        supported = (instr.r_fmt.funct7 == 7'h00) ||
                                    (instr.r_fmt.funct7 == 7'h20);
                    end
                    3'b010:  alu_op = alu_slt;
                    3'b100:  alu_op = alu_xor;
                    3'b110:  alu_op = alu_or;
                    3'b111:  alu_op = alu_and;
                    default: supported = 1'b0;
                endcase
            end
            op_load: begin // lw
                imm       = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
                wb_sel    = wb_mem;
                supported = (funct3 == 3'b010);
            end
            op_store: begin // sw
                imm       = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                             instr.s_fmt.imm_4_0};
                alu_src   = 1'b1;
                mem_write = 1'b1;
                supported = (funct3 == 3'b010);
            end
            op_branch: begin
                // b-format bits sit on the s-format fields
                imm       = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_4_0[0],
                             instr.s_fmt.imm_11_5[5:0], instr.s_fmt.imm_4_0[4:1], 1'b0};
                branch    = 1'b1;
                supported = (funct3 == 3'b000) || (funct3 == 3'b001); // beq, bne
            end
            default: supported = 1'b0;
        endcase

        if (!valid || !supported) begin
            mem_read  = 1'b0;
            mem_write = 1'b0;
            branch    = 1'b0;
            reg_write = 1'b0;
        end
    end

endmodule

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic                        branch_ex,
    input  logic                        reg_write_ex,
    input  logic                        mem_read_ex,
    input  logic                        mem_write_ex,
    input  logic                        alu_src_ex,
    input  rv_pkg::wb_sel_t             wb_sel_ex,
    input  rv_pkg::upper_sel_t          upper_sel_ex,
    input  rv_pkg::alu_op_t             alu_op_ex,
    input  logic                        valid_ex,
    input  logic [rv_pkg::pc_width-1:0] pc_ex,
    input  logic [rv_pkg::xlen-1:0]     read_data_1_ex,
    input  logic [rv_pkg::xlen-1:0]     read_data_2_ex,
    input  logic [rv_pkg::xlen-1:0]     immediate_ex,
    input  logic [2:0]                  funct3_ex,
    input  logic [4:0]                  rd_ex,
    output logic [rv_pkg::xlen-1:0]     dmem_addr,
    output logic [rv_pkg::xlen-1:0]     dmem_wdata,
    output logic                        dmem_write,
    output logic                        dmem_read,
    input  logic [rv_pkg::xlen-1:0]     dmem_rdata,
    output logic                        reg_we,
    output logic [4:0]                  reg_wa,
    output logic [rv_pkg::xlen-1:0]     reg_wd,
    output logic                        branch_taken,
    output logic [rv_pkg::pc_width-1:0] branch_target
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc_wide;
    logic            cond;

    assign pc_wide = xlen'(pc_ex);

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb begin
        case (upper_sel_ex)
            upper_pc:   op_a = pc_wide;  // auipc
            upper_zero: op_a = '0;       // lui
            default:    op_a = read_data_1_ex;
        endcase
        op_b = alu_src_ex ? immediate_ex : read_data_2_ex;

        case (alu_op_ex)
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_slt:    alu_result = xlen'($signed(op_a) < $signed(op_b));
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // beq on funct3 000, bne on 001
    assign cond          = (read_data_1_ex == read_data_2_ex) ^ funct3_ex[0];
    assign branch_taken  = valid_ex && branch_ex && cond;
    assign branch_target = pc_ex + immediate_ex[pc_width-1:0];

    assign dmem_addr  = alu_result;
    assign dmem_wdata = read_data_2_ex;
    assign dmem_write = valid_ex && mem_write_ex;
    assign dmem_read  = valid_ex && mem_read_ex;

    assign reg_we = valid_ex && reg_write_ex;
    assign reg_wa = rd_ex;

    always_comb begin
        case (wb_sel_ex)
            wb_mem:      reg_wd = dmem_rdata;
            wb_pc_plus4: reg_wd = pc_wide + xlen'(4);
            default:     reg_wd = alu_result;
        endcase
    end

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                        clk,
    input  logic                        clear,
    input  logic                        branch_taken,
    input  logic [rv_pkg::pc_width-1:0] branch_target,
    output logic [rv_pkg::pc_width-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0]     imem_data,
    output logic [rv_pkg::pc_width-1:0] pc_id,
    output rv_pkg::instr_word_t         instr_id,
    output logic                        valid_id
);
    import rv_pkg::*;

    logic [pc_width-1:0] pc;
    logic [pc_width-1:0] pc_next;

    assign pc_next   = branch_taken ? branch_target : pc + pc_width'(4);
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            pc       <= '0;
            valid_id <= 1'b0;
        end else begin
            pc       <= pc_next;
            valid_id <= !branch_taken; // squash the word fetched this cycle
        end
    end

    always_ff @(posedge clk) begin
        pc_id    <= pc;
        instr_id <= imem_data;
    end

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                        clk,
    input  logic                        clear,
    input  logic                        squash,
    input  logic                        branch_id,
    input  logic                        reg_write_id,
    input  logic                        mem_read_id,
    input  logic                        mem_write_id,
    input  logic                        alu_src_id,
    input  rv_pkg::wb_sel_t             wb_sel_id,
    input  rv_pkg::upper_sel_t          upper_sel_id,
    input  rv_pkg::alu_op_t             alu_op_id,
    input  logic                        valid_id,
    input  logic [rv_pkg::pc_width-1:0] pc_id,
    input  logic [rv_pkg::xlen-1:0]     read_data_1_id,
    input  logic [rv_pkg::xlen-1:0]     read_data_2_id,
    input  logic [rv_pkg::xlen-1:0]     immediate_id,
    input  logic [2:0]                  funct3_id,
    input  logic [4:0]                  rd_id,
    output logic                        branch_ex,
    output logic                        reg_write_ex,
    output logic                        mem_read_ex,
    output logic                        mem_write_ex,
    output logic                        alu_src_ex,
    output rv_pkg::wb_sel_t             wb_sel_ex,
    output rv_pkg::upper_sel_t          upper_sel_ex,
    output rv_pkg::alu_op_t             alu_op_ex,
    output logic                        valid_ex,
    output logic [rv_pkg::pc_width-1:0] pc_ex,
    output logic [rv_pkg::xlen-1:0]     read_data_1_ex,
    output logic [rv_pkg::xlen-1:0]     read_data_2_ex,
    output logic [rv_pkg::xlen-1:0]     immediate_ex,
    output logic [2:0]                  funct3_ex,
    output logic [4:0]                  rd_ex
);
    import rv_pkg::*;

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            branch_ex      <= 1'b0;
            reg_write_ex   <= 1'b0;
            mem_read_ex    <= 1'b0;
            mem_write_ex   <= 1'b0;
            alu_src_ex     <= 1'b0;
            wb_sel_ex      <= wb_alu;
            upper_sel_ex   <= upper_reg;
            alu_op_ex      <= alu_add;
            valid_ex       <= 1'b0;
            pc_ex          <= '0;
            read_data_1_ex <= '0;
            read_data_2_ex <= '0;
            immediate_ex   <= '0;
            funct3_ex      <= '0;
            rd_ex          <= '0;
        end else begin
            pc_ex          <= pc_id;
            read_data_1_ex <= read_data_1_id;
            read_data_2_ex <= read_data_2_id;
            immediate_ex   <= immediate_id;
            funct3_ex      <= funct3_id;
            rd_ex          <= rd_id;
            if (squash) begin // bubble
                branch_ex    <= 1'b0;
                reg_write_ex <= 1'b0;
                mem_read_ex  <= 1'b0;
                mem_write_ex <= 1'b0;
                alu_src_ex   <= 1'b0;
                wb_sel_ex    <= wb_alu;
                upper_sel_ex <= upper_reg;
                alu_op_ex    <= alu_add;
                valid_ex     <= 1'b0;
            end else begin
                branch_ex    <= branch_id;
                reg_write_ex <= reg_write_id;
                mem_read_ex  <= mem_read_id;
                mem_write_ex <= mem_write_id;
                alu_src_ex   <= alu_src_id;
                wb_sel_ex    <= wb_sel_id;
                upper_sel_ex <= upper_sel_id;
                alu_op_ex    <= alu_op_id;
                valid_ex     <= valid_id;
            end
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [rv_pkg::xlen-1:0] rd1,
    output logic [rv_pkg::xlen-1:0] rd2,
    input  logic                    we,
    input  logic [4:0]              wa,
    input  logic [rv_pkg::xlen-1:0] wd
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // ----------------------------------------
    // read ports with write-through
    // ----------------------------------------
    always_comb begin
        if (rs1 == 5'd0)                rd1 = '0;
        else if (we && wa == rs1)       rd1 = wd;
        else                            rd1 = regs[rs1];

        if (rs2 == 5'd0)                rd2 = '0;
        else if (we && wa == rs2)       rd2 = wd;
        else                            rd2 = regs[rs2];
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic                        clk,
    input  logic                        clear,
    output logic [rv_pkg::pc_width-1:0] imem_addr,
    input  logic [rv_pkg::xlen-1:0]     imem_data,
    output logic [rv_pkg::xlen-1:0]     dmem_addr,
    output logic [rv_pkg::xlen-1:0]     dmem_wdata,
    output logic                        dmem_write,
    output logic                        dmem_read,
    input  logic [rv_pkg::xlen-1:0]     dmem_rdata
);
    import rv_pkg::*;

    // ----------------------------------------
    // decode stage
    // ----------------------------------------
    logic [pc_width-1:0] pc_id;
    instr_word_t         instr_id;
    logic                valid_id;
    logic [4:0]          rs1_id, rs2_id, rd_id;
    logic [2:0]          funct3_id;
    logic [xlen-1:0]     imm_id, rd1_id, rd2_id;
    alu_op_t             alu_op_id;
    upper_sel_t          upper_sel_id;
    wb_sel_t             wb_sel_id;
    logic                alu_src_id, mem_read_id, mem_write_id, branch_id, reg_write_id;

    // ----------------------------------------
    // execute stage
    // ----------------------------------------
    logic [pc_width-1:0] pc_ex, branch_target;
    logic [xlen-1:0]     rd1_ex, rd2_ex, imm_ex, reg_wd;
    logic [4:0]          rd_ex, reg_wa;
    logic [2:0]          funct3_ex;
    alu_op_t             alu_op_ex;
    upper_sel_t          upper_sel_ex;
    wb_sel_t             wb_sel_ex;
    logic                alu_src_ex, mem_read_ex, mem_write_ex, branch_ex, reg_write_ex;
    logic                valid_ex, reg_we, branch_taken;

    fetch_stage fetch_i (
        .clk, .clear, .branch_taken, .branch_target, .imem_addr, .imem_data,
        .pc_id, .instr_id, .valid_id
    );

    decode_unit decode_i (
        .instr(instr_id), .valid(valid_id), .rs1(rs1_id), .rs2(rs2_id), .rd(rd_id),
        .funct3(funct3_id), .imm(imm_id), .alu_op(alu_op_id), .upper_sel(upper_sel_id),
        .alu_src(alu_src_id), .mem_read(mem_read_id), .mem_write(mem_write_id),
        .branch(branch_id), .reg_write(reg_write_id), .wb_sel(wb_sel_id)
    );

    reg_file regs_i (
        .clk, .rs1(rs1_id), .rs2(rs2_id), .rd1(rd1_id), .rd2(rd2_id),
        .we(reg_we), .wa(reg_wa), .wd(reg_wd)
    );

    id_ex_reg id_ex_i (
        .clk, .clear, .squash(branch_taken), // kill the instruction in decode
        .branch_id, .reg_write_id, .mem_read_id, .mem_write_id, .alu_src_id,
        .wb_sel_id, .upper_sel_id, .alu_op_id, .valid_id, .pc_id,
        .read_data_1_id(rd1_id), .read_data_2_id(rd2_id), .immediate_id(imm_id),
        .funct3_id, .rd_id,
        .branch_ex, .reg_write_ex, .mem_read_ex, .mem_write_ex, .alu_src_ex,
        .wb_sel_ex, .upper_sel_ex, .alu_op_ex, .valid_ex, .pc_ex,
        .read_data_1_ex(rd1_ex), .read_data_2_ex(rd2_ex), .immediate_ex(imm_ex),
        .funct3_ex, .rd_ex
    );

    execute_unit exec_i (
        .branch_ex, .reg_write_ex, .mem_read_ex, .mem_write_ex, .alu_src_ex,
        .wb_sel_ex, .upper_sel_ex, .alu_op_ex, .valid_ex, .pc_ex,
        .read_data_1_ex(rd1_ex), .read_data_2_ex(rd2_ex), .immediate_ex(imm_ex),
        .funct3_ex, .rd_ex,
        .dmem_addr, .dmem_wdata, .dmem_write, .dmem_read, .dmem_rdata,
        .reg_we, .reg_wa, .reg_wd, .branch_taken, .branch_target
    );

endmodule

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen     = 32;
    localparam int pc_width = 12; // 4 KB byte address space

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4} wb_sel_t;

    // first alu operand
    typedef enum logic [1:0] {upper_reg, upper_pc, upper_zero} upper_sel_t;

    // ----------------------------------------
    // instruction formats
    // ----------------------------------------
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5; // also branch imm bits 12,10:5
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;  // also branch imm bits 4:1,11
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_word_t;

endpackage

// ==== project.f ====
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/id_ex_reg.sv
hw/execute_unit.sv
hw/rv_core.sv
test/rv_core_properties.sv
test/rv_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the rv_core simulation with Verilator.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module rv_core_tb -o rv_core_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/rv_core_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit $sim_status
fi
exit 0

// ==== test/rv_core_properties.sv ====
`timescale 1ns/1ps

module rv_core_properties (
    input logic                        clk,
    input logic                        clear,
    input logic                        dmem_write,
    input logic                        dmem_read,
    input logic [rv_pkg::pc_width-1:0] imem_addr,
    input logic                        branch_taken,
    input logic [rv_pkg::pc_width-1:0] branch_target
);

    no_read_and_write: assert property (@(posedge clk) !(dmem_write && dmem_read))
        else $error("dmem_write and dmem_read both high");

    quiet_in_clear: assert property (@(posedge clk) clear |-> (!dmem_write && !dmem_read))
        else $error("data memory access while clear is high");

    word_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else $error("imem_addr not word aligned");

    // pc follows a taken branch one cycle later
    branch_redirect: assert property (@(posedge clk) disable iff (clear)
        branch_taken |=> imem_addr == $past(branch_target))
        else $error("imem_addr did not follow the branch target");

endmodule

bind rv_core rv_core_properties props_i (
    .clk(clk), .clear(clear), .dmem_write(dmem_write), .dmem_read(dmem_read),
    .imem_addr(imem_addr), .branch_taken(branch_taken), .branch_target(branch_target)
);

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int store_timeout = 200; // cycles

    logic                clk;
    logic                clear;
    logic [pc_width-1:0] imem_addr;
    logic [31:0]         imem_data;
    logic [31:0]         dmem_addr;
    logic [31:0]         dmem_wdata;
    logic                dmem_write;
    logic                dmem_read;
    logic [31:0]         dmem_rdata;

    logic [31:0] imem [1024];
    logic [31:0] dmem [1024];
    logic [9:0]  next_idx;
    int          cycle;

    logic [31:0] st_addr[$];
    logic [31:0] st_data[$];
    int          st_cycle[$];
    logic [31:0] ld_addr[$];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];

    rv_core rv_core_i (
        .clk(clk), .clear(clear), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_write(dmem_write),
        .dmem_read(dmem_read), .dmem_rdata(dmem_rdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ----------------------------------------
    // memory models
    // ----------------------------------------
    assign imem_data  = imem[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(negedge clk) begin
        if (dmem_read) begin
            ld_addr.push_back(dmem_addr);
        end
        if (dmem_write) begin
            st_addr.push_back(dmem_addr);
            st_data.push_back(dmem_wdata);
            st_cycle.push_back(cycle);
            dmem[dmem_addr[11:2]] = dmem_wdata;
        end
    end

    always @(posedge clk) begin
        if (clear) cycle <= 0;
        else       cycle <= cycle + 1; // cycle 0 starts when clear drops
    end

    // ----------------------------------------
    // instruction encoders
    // ----------------------------------------
    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op_op_imm};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, op_load};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] auipc(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, op_auipc};
    endfunction

    function automatic logic [31:0] rr(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_op};
    endfunction

    function automatic logic [31:0] bcond(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    // ----------------------------------------
    // program and check helpers
    // ----------------------------------------
    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic emit(input logic [31:0] word);
        imem[next_idx] = word;
        next_idx = next_idx + 10'd1;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800; // addi sign-extends the low part
        emit(lui(rd, hi[31:12]));
        emit(addi(rd, rd, value[11:0]));
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic hold_reset();
        @(posedge clk);
        #1;
        clear = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            imem[10'(i)] = addi(5'd0, 5'd0, 12'(i)); // harmless x0 writes
        end
        next_idx = '0;
        st_addr.delete();
        st_data.delete();
        st_cycle.delete();
        ld_addr.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic run_program(input string name);
        int waited;
        waited = 0;
        repeat (5) @(posedge clk);
        #1;
        clear = 1'b0;
        assert (imem_addr == '0) else begin
            $display("** Error at %0t: %s first imem_addr %h, expected 0",
                     $time, name, imem_addr);
            abort_run();
        end
        while (st_addr.size() < exp_addr.size()) begin
            @(posedge clk);
            waited++;
            if (waited > store_timeout) begin
                $display("%s: only %0d of %0d expected stores arrived within %0d cycles",
                         name, st_addr.size(), exp_addr.size(), store_timeout);
                abort_run();
            end
        end
        for (int k = 0; k < exp_addr.size(); k++) begin
            assert (st_addr[k] == exp_addr[k] && st_data[k] == exp_data[k]) else begin
                $display("** Error at %0t: %s store %0d wrote %h to %h, expected %h to %h",
                         $time, name, k, st_data[k], st_addr[k], exp_data[k], exp_addr[k]);
                abort_run();
            end
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic reset_test();
        hold_reset();
        emit(addi(5'd1, 5'd0, 12'd5));
        emit(addi(5'd2, 5'd0, 12'd7));
        emit(rr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(sw(5'd3, 5'd0, 12'h100));
        expect_store(32'h100, 32'd12);
        run_program("reset");
        // sw at index 3 executes two cycles after it is fetched
        assert (st_cycle[0] == 3 + 2) else begin
            $display("** Error at %0t: first store in cycle %0d, expected 5",
                     $time, st_cycle[0]);
            abort_run();
        end
    endtask

    task automatic alu_test();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom();
        b = $urandom();
        hold_reset();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(rr(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(sw(5'd3, 5'd0, 12'h200));
        emit(rr(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
        emit(sw(5'd4, 5'd0, 12'h204));
        emit(rr(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
        emit(sw(5'd5, 5'd0, 12'h208));
        emit(rr(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
        emit(sw(5'd6, 5'd0, 12'h20c));
        emit(rr(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
        emit(sw(5'd7, 5'd0, 12'h210));
        emit(rr(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));
        emit(sw(5'd8, 5'd0, 12'h214));
        emit(rr(7'h00, 3'b010, 5'd9, 5'd2, 5'd1));
        emit(sw(5'd9, 5'd0, 12'h218));
        expect_store(32'h200, a + b);
        expect_store(32'h204, a - b);
        expect_store(32'h208, a & b);
        expect_store(32'h20c, a | b);
        expect_store(32'h210, a ^ b);
        expect_store(32'h214, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expect_store(32'h218, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        run_program("alu");
    endtask

    task automatic auipc_test();
        logic [19:0] imm;
        logic [31:0] pc;
        imm = 20'($urandom());
        hold_reset();
        repeat ($urandom_range(8, 1)) emit(addi(5'd0, 5'd0, 12'd0));
        pc = {20'b0, next_idx, 2'b00};
        emit(auipc(5'd5, imm));
        emit(sw(5'd5, 5'd0, 12'h300));
        expect_store(32'h300, pc + {imm, 12'b0});
        run_program("auipc");
    endtask

    task automatic load_test();
        logic [31:0] v;
        v = $urandom();
        hold_reset();
        load_const(5'd1, v);
        emit(sw(5'd1, 5'd0, 12'h400));
        emit(lw(5'd2, 5'd0, 12'h400));
        emit(addi(5'd2, 5'd2, 12'd1));
        emit(sw(5'd2, 5'd0, 12'h404));
        expect_store(32'h400, v);
        expect_store(32'h404, v + 32'd1);
        run_program("load");
        // only the lw may raise dmem_read
        assert (ld_addr.size() == 1 && ld_addr[0] == 32'h400) else begin
            $display("** Error at %0t: load saw %0d data memory reads, expected one at 400",
                     $time, ld_addr.size());
            abort_run();
        end
    endtask

    task automatic branch_test();
        hold_reset();
        emit(addi(5'd1, 5'd0, 12'd5));
        emit(addi(5'd2, 5'd0, 12'd5));
        emit(addi(5'd3, 5'd0, 12'd6));
        emit(bcond(3'b000, 5'd1, 5'd2, 13'd12)); // beq taken
        emit(sw(5'd1, 5'd0, 12'h500));
        emit(sw(5'd1, 5'd0, 12'h504));
        emit(bcond(3'b000, 5'd1, 5'd3, 13'd12)); // beq falls through
        emit(sw(5'd1, 5'd0, 12'h508));
        emit(sw(5'd1, 5'd0, 12'h50c));
        emit(bcond(3'b001, 5'd1, 5'd3, 13'd12)); // bne taken
        emit(sw(5'd1, 5'd0, 12'h510));
        emit(sw(5'd1, 5'd0, 12'h514));
        emit(bcond(3'b001, 5'd1, 5'd2, 13'd12)); // bne falls through
        emit(sw(5'd1, 5'd0, 12'h518));
        emit(sw(5'd1, 5'd0, 12'h51c));
        expect_store(32'h508, 32'd5);
        expect_store(32'h50c, 32'd5);
        expect_store(32'h518, 32'd5);
        expect_store(32'h51c, 32'd5);
        run_program("branch");
    endtask

    task automatic zero_reg_test();
        hold_reset();
        load_const(5'd1, $urandom() | 32'd1);
        emit(rr(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
        emit(sw(5'd0, 5'd0, 12'h600));
        emit(lui(5'd0, 20'habcde));
        emit(addi(5'd0, 5'd0, 12'd123));
        emit(sw(5'd0, 5'd0, 12'h604));
        expect_store(32'h600, 32'd0);
        expect_store(32'h604, 32'd0);
        run_program("x0");
    endtask

    initial begin
        void'($urandom(71));
        clear = 1'b0;
        next_idx = '0;
        for (int i = 0; i < 1024; i++) begin
            dmem[10'(i)] = 32'hd000_0000 | (32'(i) << 4) | 32'(i);
        end
        #1;
        clear = 1'b1;
        reset_test();
        alu_test();
        auipc_test();
        load_test();
        branch_test();
        zero_reg_test();
        $display("Test passed");
        $finish;
    end

endmodule
